/* include/spm_config.svh */
`ifndef SPM_CONFIG_SVH
`define SPM_CONFIG_SVH

// bus and datapath widths
`define SPM_ADDR_W          48
`define SPM_WORD_W          64
`define SPM_COORD_W         32

// one code field per byte, type in the low bits and delta above it
`define SPM_CODE_W          8
`define SPM_CODE_TYPE_W     2
`define SPM_CODE_DELTA_W    5
`define SPM_CODES_PER_WORD  8

// address step per memory request
`define SPM_WORD_BYTES      8

// op_in field positions
`define SPM_OP_CODE_LSB     0
`define SPM_OP_REG_LSB      4
`define SPM_OP_VAL_LSB      16

// all-ones low bits marking a read reply
`define SPM_READ_MARK       12

// response buffer sizing
`define SPM_RSP_DEPTH       16
`define SPM_RSP_ALMOST      4

`endif

/* verilog/spm_pkg.sv */
`include "spm_config.svh"

package spm_pkg;

    // command opcodes, an all-zero field is a no-op
    typedef enum logic [3:0] {
        OP_RST    = 4'd1,
        OP_LD     = 4'd2,
        OP_READ   = 4'd3,
        OP_STEADY = 4'd4
    } spm_opcode_e;

    // delta code type, 3 is treated like CODE_PAD
    typedef enum logic [`SPM_CODE_TYPE_W-1:0] {
        CODE_NEWLINE  = 2'd0,
        CODE_CONSTANT = 2'd1,
        CODE_PAD      = 2'd2
    } spm_code_e;

    // register file select
    typedef enum logic [1:0] {
        REG_START_ADDR  = 2'd0,
        REG_END_ADDR    = 2'd1,
        REG_INDEX_LIMIT = 2'd2
    } spm_reg_idx_e;

    // one memory word of packed codes
    typedef logic [`SPM_WORD_W-1:0] spm_word_t;

    // coordinate pair, row in the upper half
    typedef struct packed {
        logic [`SPM_COORD_W-1:0] row;
        logic [`SPM_COORD_W-1:0] col;
    } spm_index_t;

endpackage

/* verilog/spm_fifo.sv */
`timescale 1ns/1ps

module spm_fifo #(
    parameter type payload_t = logic [63:0],
    parameter int  DEPTH     = 16,
    parameter int  ALMOST    = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     push,
    input  payload_t d,
    input  logic     pop,
    output payload_t q,
    output logic     empty,
    output logic     almost_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W + 1)'(DEPTH);
    localparam logic [PTR_W:0] AF_LEVEL = (PTR_W + 1)'(DEPTH - ALMOST);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0] count;
    logic [PTR_W:0] count_next;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count       <= count_next;
            // flag follows the occupancy after this edge
            almost_full <= count_next >= AF_LEVEL;
        end
    end

    // first-word fall-through
    assign q     = mem[rd_ptr];
    assign empty = (count == '0);

    // producers outside this module must honour almost_full in time
    a_no_push_full: assert property (@(posedge clk) disable iff (rst || flush)
        !(push && count == FULL_LEVEL));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst || flush)
        !(pop && empty));

endmodule

/* verilog/spm_cmd_fetch.sv */
`timescale 1ns/1ps
`include "spm_config.svh"

module spm_cmd_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`SPM_WORD_W-1:0]  op_in,
    input  logic                    req_mem_stall,
    input  logic                    rsp_mem_push,
    input  logic                    decoder_idle,
    input  logic                    buffer_empty,
    output logic [`SPM_WORD_W-1:0]  op_out,
    output logic                    busy,
    output logic                    req_mem_ld,
    output logic [`SPM_ADDR_W-1:0]  req_mem_addr,
    output logic [`SPM_COORD_W-1:0] index_limit,
    output logic                    start,
    output logic                    flush
);

    localparam int NUM_REGS = int'(spm_pkg::REG_INDEX_LIMIT) + 1;

    logic [`SPM_WORD_W-1:0] op_r;
    spm_pkg::spm_opcode_e opcode;
    spm_pkg::spm_reg_idx_e reg_sel;
    logic [`SPM_ADDR_W-1:0] op_val;
    logic reg_ok;
    logic [`SPM_ADDR_W-1:0] regs [NUM_REGS];
    logic [`SPM_ADDR_W-1:0] req_addr;
    logic [`SPM_ADDR_W-1:0] rcv_addr;
    logic req_mem_stall_r;
    logic running;
    logic draining;
    logic cmd_rst;
    logic range_left;
    logic issue;
    logic done;

    // command fields, decoded one cycle after op_in
    assign opcode  = spm_pkg::spm_opcode_e'(
        op_r[`SPM_OP_CODE_LSB +: $bits(spm_pkg::spm_opcode_e)]);
    assign reg_sel = spm_pkg::spm_reg_idx_e'(
        op_r[`SPM_OP_REG_LSB +: $bits(spm_pkg::spm_reg_idx_e)]);
    assign op_val  = op_r[`SPM_OP_VAL_LSB +: `SPM_ADDR_W];
    assign reg_ok  = reg_sel inside {spm_pkg::REG_START_ADDR, spm_pkg::REG_END_ADDR,
                                     spm_pkg::REG_INDEX_LIMIT};

    assign cmd_rst    = (opcode == spm_pkg::OP_RST);
    assign start      = (opcode == spm_pkg::OP_STEADY) && !busy;
    assign range_left = req_addr < regs[spm_pkg::REG_END_ADDR];
    assign issue      = running && !cmd_rst && range_left && !req_mem_stall_r;
    // run ends once everything requested has come back and been decoded
    assign done       = running && !range_left && (rcv_addr == req_addr)
                        && buffer_empty && decoder_idle;
    // responses still in flight after an abort are dropped at the buffer
    assign flush      = cmd_rst || (draining && rsp_mem_push);
    assign busy       = running || draining;

    assign index_limit = regs[spm_pkg::REG_INDEX_LIMIT][`SPM_COORD_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            op_r            <= '0;
            op_out          <= '0;
            req_mem_stall_r <= 1'b0;
            req_mem_ld      <= 1'b0;
            running         <= 1'b0;
            draining        <= 1'b0;
            regs[spm_pkg::REG_START_ADDR]  <= '0;
            regs[spm_pkg::REG_END_ADDR]    <= '0;
            regs[spm_pkg::REG_INDEX_LIMIT] <= '1;
        end else begin
            op_r            <= op_in;
            req_mem_stall_r <= req_mem_stall;
            req_mem_ld      <= issue;
            op_out          <= '0;
            if (opcode == spm_pkg::OP_READ && reg_ok) begin
                op_out[`SPM_OP_VAL_LSB +: `SPM_ADDR_W] <= regs[reg_sel];
                op_out[`SPM_READ_MARK-1:0]             <= '1;
            end
            if (opcode == spm_pkg::OP_LD && reg_ok) begin
                regs[reg_sel] <= op_val;
            end
            if (start) begin
                running <= 1'b1;
            end else if (cmd_rst || done) begin
                running <= 1'b0;
            end
            if (cmd_rst) begin
                draining <= (rcv_addr != req_addr);
            end else if (draining && rcv_addr == req_addr) begin
                draining <= 1'b0;
            end
        end
    end

    // request and receive address counters
    always_ff @(posedge clk) begin
        if (rst) begin
            req_addr <= '0;
            rcv_addr <= '0;
        end else if (start) begin
            req_addr <= regs[spm_pkg::REG_START_ADDR];
            rcv_addr <= regs[spm_pkg::REG_START_ADDR];
        end else begin
            if (issue) begin
                req_addr <= req_addr + `SPM_ADDR_W'(`SPM_WORD_BYTES);
            end
            if (rsp_mem_push) begin
                rcv_addr <= rcv_addr + `SPM_ADDR_W'(`SPM_WORD_BYTES);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_mem_addr <= req_addr;
        end
    end

    a_req_in_run: assert property (@(posedge clk) disable iff (rst)
        !running |=> !req_mem_ld);

endmodule

/* verilog/spm_index_decoder.sv */
`timescale 1ns/1ps
`include "spm_config.svh"

module spm_index_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    start,
    input  logic [`SPM_COORD_W-1:0] index_limit,
    input  logic                    word_empty,
    input  spm_pkg::spm_word_t      word_q,
    input  logic                    stall_index,
    output logic                    word_pop,
    output logic                    idle,
    output logic                    push_index,
    output logic [`SPM_COORD_W-1:0] row,
    output logic [`SPM_COORD_W-1:0] col
);

    localparam int STEP_W = $clog2(`SPM_CODES_PER_WORD);

    spm_pkg::spm_word_t word_r;
    logic word_valid;
    logic [STEP_W-1:0] step;
    logic [`SPM_CODE_W-1:0] code;
    spm_pkg::spm_code_e code_type;
    logic [`SPM_CODE_DELTA_W-1:0] delta;
    logic advance;
    logic [`SPM_COORD_W-1:0] row_acc;
    logic [`SPM_COORD_W-1:0] col_acc;
    logic [`SPM_COORD_W-1:0] col_next;
    logic [`SPM_COORD_W-1:0] limit_r;
    logic [`SPM_COORD_W-1:0] idx_count;
    logic skid_push;
    logic skid_pop;
    logic skid_empty;
    logic skid_af;
    spm_pkg::spm_index_t skid_d;
    spm_pkg::spm_index_t skid_q;

    // current code sits in the low byte, word shifts down per step
    assign code      = word_r[`SPM_CODE_W-1:0];
    assign code_type = spm_pkg::spm_code_e'(code[`SPM_CODE_TYPE_W-1:0]);
    assign delta     = code[`SPM_CODE_TYPE_W +: `SPM_CODE_DELTA_W];
    assign col_next  = col_acc + `SPM_COORD_W'(delta) + 1'b1;

    assign advance   = word_valid && !skid_af;
    assign word_pop  = !word_valid && !word_empty && !flush;
    assign skid_push = advance && (code_type == spm_pkg::CODE_CONSTANT)
                       && (idx_count < limit_r);
    assign skid_d    = '{row: row_acc, col: col_next};
    assign skid_pop  = !skid_empty && !stall_index;
    assign idle      = !word_valid && skid_empty;

    always_ff @(posedge clk) begin
        if (word_pop) begin
            word_r <= word_q;
        end else if (advance) begin
            word_r <= word_r >> `SPM_CODE_W;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            word_valid <= 1'b0;
            step       <= '0;
        end else if (word_pop) begin
            word_valid <= 1'b1;
            step       <= '0;
        end else if (advance) begin
            step <= step + 1'b1;
            if (step == STEP_W'(`SPM_CODES_PER_WORD - 1)) begin
                word_valid <= 1'b0;
            end
        end
    end

    // coordinate accumulation, column restarts at all ones on each row
    always_ff @(posedge clk) begin
        if (rst || flush || start) begin
            row_acc   <= '0;
            col_acc   <= '1;
            idx_count <= '0;
        end else if (advance) begin
            case (code_type)
                spm_pkg::CODE_NEWLINE: begin
                    row_acc <= row_acc + 1'b1;
                    col_acc <= '1;
                end
                spm_pkg::CODE_CONSTANT: begin
                    col_acc   <= col_next;
                    idx_count <= idx_count + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            limit_r <= '0;
        end else if (start) begin
            limit_r <= index_limit;
        end
    end

    spm_fifo #(
        .payload_t (spm_pkg::spm_index_t),
        .DEPTH     (4),
        .ALMOST    (1)
    ) i_skid (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .push        (skid_push),
        .d           (skid_d),
        .pop         (skid_pop),
        .q           (skid_q),
        .empty       (skid_empty),
        .almost_full (skid_af)
    );

    // output register, only loaded when stall was low at the edge
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            push_index <= 1'b0;
            row        <= '0;
            col        <= '1;
        end else begin
            push_index <= skid_pop;
            if (skid_pop) begin
                row <= skid_q.row;
                col <= skid_q.col;
            end
        end
    end

    a_no_push_after_stall: assert property (@(posedge clk) disable iff (rst)
        stall_index |=> !push_index);

endmodule

/* verilog/spm_decoder_top.sv */
`timescale 1ns/1ps
`include "spm_config.svh"

module spm_decoder_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`SPM_WORD_W-1:0]  op_in,
    input  logic                    req_mem_stall,
    input  logic                    rsp_mem_push,
    input  spm_pkg::spm_word_t      rsp_mem_q,
    input  logic                    stall_index,
    output logic [`SPM_WORD_W-1:0]  op_out,
    output logic                    busy,
    output logic                    req_mem_ld,
    output logic [`SPM_ADDR_W-1:0]  req_mem_addr,
    output logic                    rsp_mem_stall,
    output logic                    push_index,
    output logic [`SPM_COORD_W-1:0] row,
    output logic [`SPM_COORD_W-1:0] col
);

    logic [`SPM_COORD_W-1:0] index_limit;
    logic start;
    logic flush;
    logic decoder_idle;
    logic buf_empty;
    logic word_pop;
    spm_pkg::spm_word_t word_q;

    spm_cmd_fetch i_cmd_fetch (
        .clk           (clk),
        .rst           (rst),
        .op_in         (op_in),
        .req_mem_stall (req_mem_stall),
        .rsp_mem_push  (rsp_mem_push),
        .decoder_idle  (decoder_idle),
        .buffer_empty  (buf_empty),
        .op_out        (op_out),
        .busy          (busy),
        .req_mem_ld    (req_mem_ld),
        .req_mem_addr  (req_mem_addr),
        .index_limit   (index_limit),
        .start         (start),
        .flush         (flush)
    );

    // almost-full doubles as the response back-pressure
    spm_fifo #(
        .payload_t (spm_pkg::spm_word_t),
        .DEPTH     (`SPM_RSP_DEPTH),
        .ALMOST    (`SPM_RSP_ALMOST)
    ) i_rsp_buf (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .push        (rsp_mem_push),
        .d           (rsp_mem_q),
        .pop         (word_pop),
        .q           (word_q),
        .empty       (buf_empty),
        .almost_full (rsp_mem_stall)
    );

    spm_index_decoder i_index_decoder (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (start),
        .index_limit (index_limit),
        .word_empty  (buf_empty),
        .word_q      (word_q),
        .stall_index (stall_index),
        .word_pop    (word_pop),
        .idle        (decoder_idle),
        .push_index  (push_index),
        .row         (row),
        .col         (col)
    );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 40.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // release on a falling edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* sim/tb_spm_decoder.sv */
`timescale 1ns/1ps
`include "spm_config.svh"

module tb_spm_decoder;

    logic clk;
    logic rst;
    logic [`SPM_WORD_W-1:0] op_in;
    logic req_mem_stall = 1'b0;
    logic rsp_mem_push = 1'b0;
    spm_pkg::spm_word_t rsp_mem_q = '0;
    logic stall_index = 1'b0;
    logic [`SPM_WORD_W-1:0] op_out;
    logic busy;
    logic req_mem_ld;
    logic [`SPM_ADDR_W-1:0] req_mem_addr;
    logic rsp_mem_stall;
    logic push_index;
    logic [`SPM_COORD_W-1:0] row;
    logic [`SPM_COORD_W-1:0] col;

    // registers as last loaded over the command bus
    logic [`SPM_ADDR_W-1:0] shadow_regs [3];
    // expected pair stream of the current run
    logic [`SPM_COORD_W-1:0] exp_rows [$];
    logic [`SPM_COORD_W-1:0] exp_cols [$];
    logic [`SPM_COORD_W-1:0] exp_row;
    logic [`SPM_COORD_W-1:0] exp_col;
    int exp_pos;
    int exp_left;
    logic [`SPM_ADDR_W-1:0] exp_addr;
    logic [`SPM_WORD_W-1:0] reply_d1;
    logic [`SPM_WORD_W-1:0] reply_d2;
    // memory model
    logic [`SPM_ADDR_W-1:0] pend_addr [$];
    int pend_due [$];
    int cycle = 0;
    logic [63:0] rng = 64'd66;

    tb_clock_gen #(.PERIOD_NS(40.0), .RESET_CYCLES(10)) i_clock_gen (.clk(clk), .rst(rst));

    spm_decoder_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .op_in         (op_in),
        .req_mem_stall (req_mem_stall),
        .rsp_mem_push  (rsp_mem_push),
        .rsp_mem_q     (rsp_mem_q),
        .stall_index   (stall_index),
        .op_out        (op_out),
        .busy          (busy),
        .req_mem_ld    (req_mem_ld),
        .req_mem_addr  (req_mem_addr),
        .rsp_mem_stall (rsp_mem_stall),
        .push_index    (push_index),
        .row           (row),
        .col           (col)
    );

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    // eight codes per word derived from the address
    function automatic spm_pkg::spm_word_t word_at(input logic [`SPM_ADDR_W-1:0] addr);
        logic [63:0] s;
        spm_pkg::spm_word_t w;
        s = {addr, 16'd66};
        for (int i = 0; i < `SPM_CODES_PER_WORD; i++) begin
            s = xorshift(s);
            w[i*`SPM_CODE_W +: `SPM_CODE_W] = {1'b0, s[12:8], s[1:0]};
        end
        return w;
    endfunction

    task automatic stop_on_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        stop_on_failure();
    endtask

    task automatic report_failure(input string what);
        $display("%s (at %0t)", what, $time);
        stop_on_failure();
    endtask

    task automatic send_cmd(input spm_pkg::spm_opcode_e op, input spm_pkg::spm_reg_idx_e sel,
                            input logic [`SPM_ADDR_W-1:0] value);
        @(negedge clk);
        op_in = {value, 10'b0, sel, op};
        if (op == spm_pkg::OP_LD) begin
            shadow_regs[sel] = value;
        end
        @(negedge clk);
        op_in = '0;
    endtask

    // walks the codes of the whole range in order
    task automatic build_reference(input logic [`SPM_ADDR_W-1:0] first,
                                   input logic [`SPM_ADDR_W-1:0] last,
                                   input logic [`SPM_COORD_W-1:0] limit);
        logic [`SPM_COORD_W-1:0] r;
        logic [`SPM_COORD_W-1:0] c;
        logic [`SPM_COORD_W-1:0] cnt;
        logic [`SPM_ADDR_W-1:0] a;
        spm_pkg::spm_word_t w;
        logic [`SPM_CODE_W-1:0] b;
        exp_rows.delete();
        exp_cols.delete();
        r = '0;
        c = '1;
        cnt = '0;
        for (a = first; a < last; a = a + `SPM_ADDR_W'(`SPM_WORD_BYTES)) begin
            w = word_at(a);
            for (int i = 0; i < `SPM_CODES_PER_WORD; i++) begin
                b = w[i*`SPM_CODE_W +: `SPM_CODE_W];
                if (b[1:0] == spm_pkg::CODE_NEWLINE) begin
                    r = r + 32'd1;
                    c = '1;
                end else if (b[1:0] == spm_pkg::CODE_CONSTANT) begin
                    c = c + 32'(b[6:2]) + 32'd1;
                    if (cnt < limit) begin
                        exp_rows.push_back(r);
                        exp_cols.push_back(c);
                    end
                    cnt = cnt + 32'd1;
                end
            end
        end
    endtask

    task automatic wait_busy(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (busy !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            report_failure({"timeout while waiting for ", what});
        end
    endtask

    task automatic wait_pushes(input int count, input int max_cycles);
        int n;
        n = 0;
        while (exp_pos < count && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_pos < count) begin
            report_failure("timeout while waiting for index pushes");
        end
    endtask

    task automatic start_run(input logic [`SPM_ADDR_W-1:0] first, input int words,
                             input logic [`SPM_COORD_W-1:0] limit);
        logic [`SPM_ADDR_W-1:0] last;
        last = first + `SPM_ADDR_W'(words * `SPM_WORD_BYTES);
        send_cmd(spm_pkg::OP_LD, spm_pkg::REG_START_ADDR, first);
        send_cmd(spm_pkg::OP_LD, spm_pkg::REG_END_ADDR, last);
        send_cmd(spm_pkg::OP_LD, spm_pkg::REG_INDEX_LIMIT, `SPM_ADDR_W'(limit));
        build_reference(first, last, limit);
        send_cmd(spm_pkg::OP_STEADY, spm_pkg::REG_START_ADDR, '0);
        wait_busy(1'b1, 8, "busy to rise");
    endtask

    task automatic check_run_end();
        a_pairs_done: assert (exp_left == 0)
            else report_value("pairs left in the stream", 64'(exp_left), 64'd0);
        a_range_done: assert (exp_addr == shadow_regs[spm_pkg::REG_END_ADDR])
            else report_value("next request address", 64'(exp_addr),
                              64'(shadow_regs[spm_pkg::REG_END_ADDR]));
    endtask

    // memory replies and random stalls move on the falling edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        rng = xorshift(rng);
        req_mem_stall = rng[3:0] < 4'd4;
        stall_index = rng[7:4] < 4'd5;
        if (req_mem_ld) begin
            pend_addr.push_back(req_mem_addr);
            pend_due.push_back(cycle + 1 + int'(rng[9:8]));
        end
        rsp_mem_push = 1'b0;
        if (!rst && !rsp_mem_stall && pend_addr.size() > 0 && pend_due[0] <= cycle) begin
            rsp_mem_push = 1'b1;
            rsp_mem_q = word_at(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
    end

    // expected values for the assertions below
    always @(posedge clk) begin
        reply_d1 <= '0;
        if (op_in[3:0] == spm_pkg::OP_READ && op_in[5:4] != 2'd3) begin
            reply_d1 <= {shadow_regs[op_in[5:4]], 4'h0, {`SPM_READ_MARK{1'b1}}};
        end
        reply_d2 <= reply_d1;
        if (rst) begin
            exp_addr <= '0;
            exp_pos  <= 0;
            exp_left <= 0;
        end else if (op_in[3:0] == spm_pkg::OP_STEADY) begin
            exp_addr <= shadow_regs[spm_pkg::REG_START_ADDR];
            exp_pos  <= 0;
            exp_left <= exp_rows.size();
            exp_row  <= exp_rows.size() > 0 ? exp_rows[0] : '0;
            exp_col  <= exp_cols.size() > 0 ? exp_cols[0] : '0;
        end else begin
            if (req_mem_ld) begin
                exp_addr <= exp_addr + `SPM_ADDR_W'(`SPM_WORD_BYTES);
            end
            if (push_index) begin
                exp_pos  <= exp_pos + 1;
                exp_left <= exp_left - 1;
                if (exp_pos + 1 < exp_rows.size()) begin
                    exp_row <= exp_rows[exp_pos + 1];
                    exp_col <= exp_cols[exp_pos + 1];
                end
            end
        end
    end

    a_reset_outputs: assert property (@(posedge clk) $fell(rst) |->
        {busy, req_mem_ld, push_index, rsp_mem_stall, |op_out} == 5'b0)
        else report_value("{busy,req_mem_ld,push_index,rsp_mem_stall,op_out}",
            64'({$sampled(busy), $sampled(req_mem_ld), $sampled(push_index),
                 $sampled(rsp_mem_stall), |$sampled(op_out)}), 64'd0);
    a_op_out: assert property (@(posedge clk) disable iff (rst) op_out == reply_d2)
        else report_value("op_out", $sampled(op_out), $sampled(reply_d2));
    a_busy_rise: assert property (@(posedge clk) disable iff (rst)
        $past(op_in[3:0] == spm_pkg::OP_STEADY && !busy, 2) |-> busy)
        else report_value("busy", 64'($sampled(busy)), 64'd1);
    a_req_order: assert property (@(posedge clk) disable iff (rst)
        req_mem_ld |-> req_mem_addr == exp_addr)
        else report_value("req_mem_addr", 64'($sampled(req_mem_addr)), 64'($sampled(exp_addr)));
    a_req_range: assert property (@(posedge clk) disable iff (rst)
        req_mem_ld |-> req_mem_addr[2:0] == 3'b0
            && req_mem_addr >= shadow_regs[spm_pkg::REG_START_ADDR]
            && req_mem_addr < shadow_regs[spm_pkg::REG_END_ADDR])
        else report_failure("memory request outside the address range or not aligned");
    a_pair_extra: assert property (@(posedge clk) disable iff (rst)
        push_index |-> exp_left > 0)
        else report_failure("push_index with no pair left in the expected stream");
    a_pair_row: assert property (@(posedge clk) disable iff (rst)
        push_index |-> row == exp_row)
        else report_value("row", 64'($sampled(row)), 64'($sampled(exp_row)));
    a_pair_col: assert property (@(posedge clk) disable iff (rst)
        push_index |-> col == exp_col)
        else report_value("col", 64'($sampled(col)), 64'($sampled(exp_col)));
    a_stall_push: assert property (@(posedge clk) disable iff (rst)
        stall_index |=> !push_index)
        else report_failure("push_index rose in the cycle after stall_index was high");

    initial begin
        int n;
        op_in = '0;
        shadow_regs[spm_pkg::REG_START_ADDR]  = '0;
        shadow_regs[spm_pkg::REG_END_ADDR]    = '0;
        shadow_regs[spm_pkg::REG_INDEX_LIMIT] = '1;
        n = 0;
        // reset generator drives rst from its own time-zero block
        @(negedge clk);
        while (rst && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            report_failure("reset was never released");
        end

        // register readback
        send_cmd(spm_pkg::OP_LD, spm_pkg::REG_START_ADDR, 48'h0000_dead_bee8);
        send_cmd(spm_pkg::OP_READ, spm_pkg::REG_START_ADDR, '0);
        send_cmd(spm_pkg::OP_LD, spm_pkg::REG_END_ADDR, 48'h1234_5678_9ab0);
        send_cmd(spm_pkg::OP_READ, spm_pkg::REG_END_ADDR, '0);
        send_cmd(spm_pkg::OP_LD, spm_pkg::REG_INDEX_LIMIT, 48'h0000_0000_0abc);
        send_cmd(spm_pkg::OP_READ, spm_pkg::REG_INDEX_LIMIT, '0);
        send_cmd(spm_pkg::OP_READ, spm_pkg::REG_START_ADDR, '0);

        // full run without a limit
        start_run(48'h0000_0001_0000, 32, '1);
        wait_busy(1'b0, 5000, "busy to fall after a full run");
        check_run_end();

        // limit well below the number of constant codes
        start_run(48'h0000_0002_0040, 24, 32'd5);
        wait_busy(1'b0, 5000, "busy to fall after a limited run");
        check_run_end();

        // abort in the middle and restart from row 0
        start_run(48'h0000_0003_0000, 64, '1);
        wait_pushes(6, 2000);
        send_cmd(spm_pkg::OP_RST, spm_pkg::REG_START_ADDR, '0);
        wait_busy(1'b0, 200, "busy to fall after an abort");
        start_run(48'h0000_0003_0000, 16, '1);
        wait_busy(1'b0, 5000, "busy to fall after the run that follows an abort");
        check_run_end();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
verilog/spm_pkg.sv
verilog/spm_fifo.sv
verilog/spm_cmd_fetch.sv
verilog/spm_index_decoder.sv
verilog/spm_decoder_top.sv
sim/tb_clock_gen.sv
sim/tb_spm_decoder.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_spm_decoder

# the grep decides the exit status of the pipeline
./obj_dir/Vtb_spm_decoder | tee /dev/stderr | grep "TESTBENCH PASSED"
